// File: src.f
src/uart_pkg.sv
src/uart_chan_if.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_wb_regs.sv
src/uart_top.sv
testbench/tb_uart_top.sv

// File: Bender.yml
package:
  name: uart_wb

sources:
  - src/uart_pkg.sv
  - src/uart_chan_if.sv
  - src/uart_tx.sv
  - src/uart_rx.sv
  - src/uart_wb_regs.sv
  - src/uart_top.sv
  - target: test
    files:
      - testbench/tb_uart_top.sv

// File: testbench/tb_uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_top;
    import uart_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int DRV_DLY    = 2;
    localparam int N_FRAMES   = 24;
    localparam int POLL_LIMIT = 400;
    localparam int WATCHDOG_NS = 2 * N_FRAMES * 10 * DEFAULT_BAUD_DIV * CLK_PERIOD + 10000;

    logic                 clk;
    logic                 rstn;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_ADR_W-1:0]  wb_adr;
    logic [WB_DATA_W-1:0] wb_wdat;
    logic [WB_DATA_W-1:0] wb_rdat;
    logic                 wb_ack;
    logic                 uart_tx;
    logic                 uart_rx;
    logic                 loopback;
    logic                 drv_line;
    int unsigned          cur_div;
    integer               seed;
    logic [9:0]           exp_frames[$];
    logic [9:0]           got_frames[$];
    int                   n_sent;
    int                   n_checked;
    logic                 m_rx_valid;   // flag model.
    logic                 m_frame_err;
    logic                 m_overrun;
    logic                 m_drop;

    assign uart_rx = loopback ? uart_tx : drv_line;

    uart_top u_uart_top (
        .clk_i     (clk),
        .rstn_i    (rstn),
        .wb_cyc_i  (wb_cyc),
        .wb_stb_i  (wb_stb),
        .wb_we_i   (wb_we),
        .wb_adr_i  (wb_adr),
        .wb_dat_i  (wb_wdat),
        .uart_rx_i (uart_rx),
        .wb_dat_o  (wb_rdat),
        .wb_ack_o  (wb_ack),
        .uart_tx_o (uart_tx)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // start bit in bit 0, data lsb first, stop bit on top.
    function automatic logic [9:0] ref_frame(input logic [DATA_W-1:0] b);
        return {1'b1, b, 1'b0};
    endfunction

    function automatic logic [WB_DATA_W-1:0] ref_status(input logic busy, input logic rxv,
                                                        input logic fe, input logic ov,
                                                        input logic drop);
        logic [WB_DATA_W-1:0] w;
        w                = '0;
        w[ST_TX_BUSY]    = busy;
        w[ST_RX_VALID]   = rxv;
        w[ST_FRAME_ERR]  = fe;
        w[ST_RX_OVERRUN] = ov;
        w[ST_TX_DROP]    = drop;
        return w;
    endfunction

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
            abort_run();
        end
    endtask

    // ack must come one cycle after the request.
    task automatic wait_ack();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #DRV_DLY;
            n++;
            if (n > 8) begin
                $display("the Wishbone slave gave no ack within 8 cycles");
                abort_run();
            end
        end while (!wb_ack);
        check_value("wb_ack_o latency", 1, n);
    endtask

    task automatic write_reg(input logic [WB_ADR_W-1:0] adr, input logic [WB_DATA_W-1:0] dat);
        wb_cyc  = 1'b1;
        wb_stb  = 1'b1;
        wb_we   = 1'b1;
        wb_adr  = adr;
        wb_wdat = dat;
        wait_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);   // one idle cycle between accesses.
        #DRV_DLY;
    endtask

    task automatic read_reg(input logic [WB_ADR_W-1:0] adr, output logic [WB_DATA_W-1:0] dat);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack();
        dat    = wb_rdat;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(posedge clk);
        #DRV_DLY;
    endtask

    // a status read clears the sticky flags.
    task automatic check_status(input logic busy, input logic [WB_DATA_W-1:0] st);
        check_value("STATUS", ref_status(busy, m_rx_valid, m_frame_err, m_overrun, m_drop), st);
        m_frame_err = 1'b0;
        m_overrun   = 1'b0;
        m_drop      = 1'b0;
    endtask

    task automatic expect_status(input logic busy);
        logic [WB_DATA_W-1:0] st;
        read_reg(ADDR_STATUS, st);
        check_status(busy, st);
    endtask

    task automatic poll_status(input int idx, input logic need_idle,
                               output logic [WB_DATA_W-1:0] st);
        int n;
        n = 0;
        do begin
            read_reg(ADDR_STATUS, st);
            n++;
            if (n > POLL_LIMIT) begin
                $display("STATUS bit %0d did not come up within %0d reads", idx, POLL_LIMIT);
                abort_run();
            end
        end while (!st[idx] || (need_idle && st[ST_TX_BUSY]));
    endtask

    task automatic set_baud(input int unsigned div);
        logic [WB_DATA_W-1:0] rd;
        write_reg(ADDR_BAUD, div);
        cur_div = div;
        read_reg(ADDR_BAUD, rd);
        check_value("BAUD", div, rd);
    endtask

    task automatic read_rx(input logic [DATA_W-1:0] b);
        logic [WB_DATA_W-1:0] rd;
        read_reg(ADDR_RXDATA, rd);
        check_value("RXDATA", b, rd);
        m_rx_valid = 1'b0;
        expect_status(1'b0);
    endtask

    task automatic receive_byte(input logic [DATA_W-1:0] b, input logic need_idle);
        logic [WB_DATA_W-1:0] st;
        poll_status(ST_RX_VALID, need_idle, st);
        m_rx_valid = 1'b1;
        check_status(1'b0, st);
        read_rx(b);
    endtask

    task automatic send_byte(input logic [DATA_W-1:0] b);
        write_reg(ADDR_TXDATA, b);
        exp_frames.push_back(ref_frame(b));
        n_sent++;
    endtask

    task automatic loop_byte(input logic [DATA_W-1:0] b);
        send_byte(b);
        expect_status(1'b1);
        receive_byte(b, 1'b1);
    endtask

    task automatic drive_frame(input logic [DATA_W-1:0] b, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            drv_line = bits[i];
            repeat (cur_div) @(posedge clk);
            #DRV_DLY;
        end
        drv_line = 1'b1;
    endtask

    // samples uart_tx_o at the middle of each bit.
    initial begin : line_monitor
        logic [9:0]  frame;
        int unsigned div;
        forever begin
            @(negedge uart_tx);
            div = cur_div;
            repeat (div / 2) @(negedge clk);
            for (int i = 0; i < 10; i++) begin
                frame[i] = uart_tx;
                if (i < 9) begin
                    repeat (div) @(negedge clk);
                end
            end
            got_frames.push_back(frame);
        end
    end

    initial begin : frame_compare
        logic [9:0] got;
        forever begin
            wait (got_frames.size() > 0);
            got = got_frames.pop_front();
            if (exp_frames.size() == 0) begin
                $display("a frame %b appeared on uart_tx_o with no byte sent for it", got);
                abort_run();
            end else begin
                check_value("uart_tx_o frame", exp_frames.pop_front(), got);
                n_checked++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("the run hung and did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    initial begin : stimulus
        logic [WB_DATA_W-1:0] rd;
        logic [WB_DATA_W-1:0] st;
        logic [DATA_W-1:0]    b;
        rstn        = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_wdat     = '0;
        loopback    = 1'b0;
        drv_line    = 1'b1;
        seed        = 32'h4dcc;
        cur_div     = DEFAULT_BAUD_DIV;
        n_sent      = 0;
        n_checked   = 0;
        m_rx_valid  = 1'b0;
        m_frame_err = 1'b0;
        m_overrun   = 1'b0;
        m_drop      = 1'b0;
        repeat (10) @(posedge clk);
        #DRV_DLY;
        rstn     = 1'b1;
        loopback = 1'b1;

        check_value("uart_tx_o", 1, uart_tx);
        check_value("wb_ack_o", 0, wb_ack);
        expect_status(1'b0);
        read_reg(ADDR_BAUD, rd);
        check_value("BAUD", DEFAULT_BAUD_DIV, rd);
        read_reg(ADDR_TXDATA, rd);
        check_value("TXDATA", 0, rd);

        set_baud(8);
        repeat (4) begin
            b = DATA_W'($random(seed));
            loop_byte(b);
        end
        set_baud(5);
        repeat (16) begin
            b = DATA_W'($random(seed));
            loop_byte(b);
        end

        // second write lands while the first frame is on the line.
        b = DATA_W'($random(seed));
        send_byte(b);
        write_reg(ADDR_TXDATA, ~b);
        m_drop = 1'b1;
        expect_status(1'b1);
        expect_status(1'b1);
        receive_byte(b, 1'b1);

        // two driven frames with no read between them.
        loopback = 1'b0;
        b = DATA_W'($random(seed));
        drive_frame(b, 1'b1);
        b = DATA_W'($random(seed));
        drive_frame(b, 1'b1);
        poll_status(ST_RX_OVERRUN, 1'b0, st);
        m_rx_valid = 1'b1;
        m_overrun  = 1'b1;
        check_status(1'b0, st);
        expect_status(1'b0);
        read_rx(b);

        // low stop bit.
        b = DATA_W'($random(seed));
        m_frame_err = 1'b1;
        drive_frame(b, 1'b0);
        receive_byte(b, 1'b0);

        repeat (20) @(posedge clk);
        check_value("frames seen on uart_tx_o", n_sent, n_checked);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [uart_pkg::WB_ADR_W-1:0]  wb_adr_i,
    input  logic [uart_pkg::WB_DATA_W-1:0] wb_dat_i,
    input  logic                           uart_rx_i,
    output logic [uart_pkg::WB_DATA_W-1:0] wb_dat_o,
    output logic                           wb_ack_o,
    output logic                           uart_tx_o
);

    // one channel per direction.
    uart_chan_if tx_chan ();
    uart_chan_if rx_chan ();

    uart_wb_regs u_regs (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .tx_chan_o (tx_chan),
        .rx_chan_i (rx_chan)
    );

    uart_tx u_tx (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .chan_i (tx_chan),
        .tx_o   (uart_tx_o)
    );

    uart_rx u_rx (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .rx_i   (uart_rx_i),
        .chan_o (rx_chan)
    );

endmodule

`default_nettype wire

// File: src/uart_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_wb_regs (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [uart_pkg::WB_ADR_W-1:0]  wb_adr_i,
    input  logic [uart_pkg::WB_DATA_W-1:0] wb_dat_i,
    output logic [uart_pkg::WB_DATA_W-1:0] wb_dat_o,
    output logic                           wb_ack_o,
    uart_chan_if.ctrl                      tx_chan_o,
    uart_chan_if.ctrl                      rx_chan_i
);
    import uart_pkg::*;

    logic                 req;
    logic                 wr_en;
    logic                 rd_en;
    logic [DIV_W-1:0]     baud_q;
    logic [DATA_W-1:0]    tx_data_q;
    logic                 tx_strobe_q;
    logic                 tx_busy;
    logic [DATA_W-1:0]    rx_data_q;
    logic                 rx_valid_q;
    logic                 frame_err_q;
    logic                 overrun_q;
    logic                 drop_q;
    logic [WB_DATA_W-1:0] status_w;
    logic [WB_DATA_W-1:0] rd_data;

    // a request not yet acked.
    assign req   = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wr_en = req && wb_we_i;
    assign rd_en = req && !wb_we_i;

    // strobe in flight counts as busy until the transmitter answers.
    assign tx_busy = tx_chan_o.busy || tx_strobe_q;

    always_comb begin
        status_w                = '0;
        status_w[ST_TX_BUSY]    = tx_busy;
        status_w[ST_RX_VALID]   = rx_valid_q;
        status_w[ST_FRAME_ERR]  = frame_err_q;
        status_w[ST_RX_OVERRUN] = overrun_q;
        status_w[ST_TX_DROP]    = drop_q;
    end

    always_comb begin
        case (wb_adr_i)
            ADDR_RXDATA: rd_data = WB_DATA_W'(rx_data_q);
            ADDR_STATUS: rd_data = status_w;
            ADDR_BAUD:   rd_data = WB_DATA_W'(baud_q);
            default:     rd_data = '0;   // txdata is write only.
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= req;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            wb_dat_o <= rd_data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            baud_q      <= DEFAULT_BAUD_DIV;
            tx_strobe_q <= 1'b0;
            rx_valid_q  <= 1'b0;
            frame_err_q <= 1'b0;
            overrun_q   <= 1'b0;
            drop_q      <= 1'b0;
        end else begin
            tx_strobe_q <= 1'b0;
            if (wr_en && wb_adr_i == ADDR_BAUD) begin
                baud_q <= wb_dat_i[DIV_W-1:0];
            end
            if (wr_en && wb_adr_i == ADDR_TXDATA) begin
                if (tx_busy) begin
                    drop_q <= 1'b1;
                end else begin
                    tx_strobe_q <= 1'b1;
                end
            end
            if (rd_en && wb_adr_i == ADDR_RXDATA) begin
                rx_valid_q <= 1'b0;
            end
            if (rd_en && wb_adr_i == ADDR_STATUS) begin
                frame_err_q <= 1'b0;
                overrun_q   <= 1'b0;
                drop_q      <= 1'b0;
            end
            // new byte wins over a clear in the same cycle.
            if (rx_chan_i.strobe) begin
                rx_valid_q <= 1'b1;
                if (rx_valid_q && !(rd_en && wb_adr_i == ADDR_RXDATA)) begin
                    overrun_q <= 1'b1;
                end
                if (rx_chan_i.frame_err) begin
                    frame_err_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en && wb_adr_i == ADDR_TXDATA && !tx_busy) begin
            tx_data_q <= wb_dat_i[DATA_W-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_chan_i.strobe) begin
            rx_data_q <= rx_chan_i.data;
        end
    end

    assign tx_chan_o.data     = tx_data_q;
    assign tx_chan_o.strobe   = tx_strobe_q;
    assign tx_chan_o.baud_div = baud_q;
    assign rx_chan_i.baud_div = baud_q;

    a_ack_single: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        wb_ack_o |=> !wb_ack_o
    );

    // both serial engines rely on at least a few cycles per bit.
    a_baud_min: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        baud_q >= MIN_BAUD_DIV
    );

endmodule

`default_nettype wire

// File: src/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic   clk_i,
    input  logic   rstn_i,
    input  logic   rx_i,
    uart_chan_if.phy chan_o
);
    import uart_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_e;

    state_e               state_q;
    logic [1:0]           sync_q;
    logic                 rx_s;
    logic                 rx_prev_q;
    logic                 fall;
    logic [DIV_W-1:0]     cnt_q;
    logic [BIT_CNT_W-1:0] bit_cnt_q;
    logic [DATA_W-1:0]    shift_q;
    logic                 strobe_q;
    logic                 frame_err_q;
    logic                 half_end;
    logic                 bit_end;

    assign rx_s     = sync_q[1];
    assign fall     = rx_prev_q && !rx_s;
    assign half_end = (cnt_q >= (chan_o.baud_div >> 1) - 1'b1);
    assign bit_end  = (cnt_q >= chan_o.baud_div - 1'b1);

    // two-flop synchronizer and edge history.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            sync_q    <= 2'b11;
            rx_prev_q <= 1'b1;
        end else begin
            sync_q    <= {sync_q[0], rx_i};
            rx_prev_q <= rx_s;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q     <= IDLE;
            cnt_q       <= '0;
            bit_cnt_q   <= '0;
            strobe_q    <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            strobe_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (fall) begin
                        state_q <= START;
                        cnt_q   <= DIV_W'(1);   // edge seen one cycle late.
                    end
                end
                START: begin
                    if (half_end) begin
                        cnt_q <= '0;
                        if (!rx_s) begin
                            state_q   <= DATA;
                            bit_cnt_q <= '0;
                        end else begin
                            state_q <= IDLE;   // glitch, not a start bit.
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        cnt_q     <= '0;
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == BIT_CNT_W'(DATA_W - 1)) begin
                            state_q <= STOP;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        cnt_q       <= '0;
                        strobe_q    <= 1'b1;
                        frame_err_q <= !rx_s;   // stop bit must be high.
                        state_q     <= IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // samples taken mid-bit, lsb arrives first.
    always_ff @(posedge clk_i) begin
        if (state_q == DATA && bit_end) begin
            shift_q <= {rx_s, shift_q[DATA_W-1:1]};
        end
    end

    assign chan_o.data      = shift_q;
    assign chan_o.strobe    = strobe_q;
    assign chan_o.frame_err = frame_err_q;
    assign chan_o.busy      = 1'b0;   // unused on this channel.

    a_strobe_one_cycle: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        strobe_q |=> !strobe_q
    );

endmodule

`default_nettype wire

// File: src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic   clk_i,
    input  logic   rstn_i,
    uart_chan_if.phy chan_i,
    output logic   tx_o
);
    import uart_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        STOP
    } state_e;

    state_e               state_q;
    logic [DIV_W-1:0]     cnt_q;
    logic [BIT_CNT_W-1:0] bit_cnt_q;
    logic [DATA_W-1:0]    shift_q;
    logic                 tx_q;
    logic                 busy_q;
    logic                 bit_end;

    // >= so a divisor lowered mid-frame cannot stall the counter.
    assign bit_end = (cnt_q >= chan_i.baud_div - 1'b1);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            bit_cnt_q <= '0;
            tx_q      <= 1'b1;   // line idles high.
            busy_q    <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (chan_i.strobe) begin
                        state_q   <= DATA;
                        cnt_q     <= '0;
                        bit_cnt_q <= '0;
                        tx_q      <= 1'b0;   // start bit.
                        busy_q    <= 1'b1;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        cnt_q <= '0;
                        if (bit_cnt_q == BIT_CNT_W'(DATA_W)) begin
                            tx_q    <= 1'b1;   // stop bit.
                            state_q <= STOP;
                        end else begin
                            tx_q      <= shift_q[0];
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        cnt_q   <= '0;
                        busy_q  <= 1'b0;
                        state_q <= IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // byte is captured on the strobe, lsb goes out first.
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && chan_i.strobe) begin
            shift_q <= chan_i.data;
        end else if (state_q == DATA && bit_end && bit_cnt_q != BIT_CNT_W'(DATA_W)) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign tx_o             = tx_q;
    assign chan_i.busy      = busy_q;
    assign chan_i.frame_err = 1'b0;   // unused on this channel.

    // the register block must hold off while a frame is in flight.
    a_no_strobe_when_busy: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        chan_i.strobe |-> !busy_q
    );

endmodule

`default_nettype wire

// File: src/uart_chan_if.sv
`timescale 1ns/1ps
`default_nettype none

interface uart_chan_if;
    import uart_pkg::*;

    wire  [DATA_W-1:0] data;   // tx: from regs, rx: from receiver.
    wire               strobe;
    logic              busy;
    logic              frame_err;
    logic [DIV_W-1:0]  baud_div;

    modport ctrl (
        inout  data,
        inout  strobe,
        output baud_div,
        input  busy,
        input  frame_err
    );

    modport phy (
        inout  data,
        inout  strobe,
        input  baud_div,
        output busy,
        output frame_err
    );

endinterface

`default_nettype wire

// File: src/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // bus geometry.
    localparam int WB_DATA_W = 32;
    localparam int WB_ADR_W  = 2;

    // character and divisor widths.
    localparam int DIV_W     = 16;
    localparam int DATA_W    = 8;
    localparam int BIT_CNT_W = $clog2(DATA_W + 1);

    localparam logic [DIV_W-1:0] DEFAULT_BAUD_DIV = 16'd16;
    localparam logic [DIV_W-1:0] MIN_BAUD_DIV     = 16'd4;

    // word addresses.
    localparam logic [WB_ADR_W-1:0] ADDR_TXDATA = 2'd0;
    localparam logic [WB_ADR_W-1:0] ADDR_RXDATA = 2'd1;
    localparam logic [WB_ADR_W-1:0] ADDR_STATUS = 2'd2;
    localparam logic [WB_ADR_W-1:0] ADDR_BAUD   = 2'd3;

    // status word bit positions.
    localparam int ST_TX_BUSY    = 0;
    localparam int ST_RX_VALID   = 1;
    localparam int ST_FRAME_ERR  = 2;
    localparam int ST_RX_OVERRUN = 3;
    localparam int ST_TX_DROP    = 4;

endpackage

`default_nettype wire
